// ==== Bender.yml ====
package:
  name: lrelu_engine

sources:
  - common/lrelu_pkg.sv
  - lrelu_engine/lrelu_config_fsm.sv
  - lrelu_engine/lrelu_dw_converter.sv
  - lrelu_engine/lrelu_datapath.sv
  - source/lrelu_reg_slice.sv
  - source/lrelu_top.sv
  - target: test
    files:
      - testbench/lrelu_tb.sv

// ==== common/lrelu_pkg.sv ====
package lrelu_pkg;

    // word widths along the stream
    localparam int ACC_WIDTH   = 32;  // accumulator word at the slave side
    localparam int WORD_WIDTH  = 8;   // requantized output word
    localparam int MULT_WIDTH  = 16;  // signed per-lane multipliers
    localparam int SHIFT_WIDTH = 5;   // rounding right shift amount

    // beats of in-band config that follow every tlast
    localparam int CONFIG_BEATS = 2;

    // field positions inside the member 0 word of a config beat
    // beat 1 carries the positive multiplier and the shift
    // beat 2 carries the negative (leaky) multiplier
    localparam int CFG_MULT_LSB  = 0;
    localparam int CFG_SHIFT_LSB = 16;

    // iteration controller states
    typedef enum logic [2:0] {
        ST_PASS    = 3'd0,  // slave stream feeds the width converter
        ST_BLOCK   = 3'd1,  // wait for the last word of the iteration to drain
        ST_RESET   = 3'd2,  // one enabled cycle that clears the lane config
        ST_WRITE_1 = 3'd3,  // first config beat
        ST_WRITE_2 = 3'd4   // remaining config beats
    } cfg_state_e;

endpackage

// ==== filelist.f ====
common/lrelu_pkg.sv
lrelu_engine/lrelu_config_fsm.sv
lrelu_engine/lrelu_dw_converter.sv
lrelu_engine/lrelu_datapath.sv
source/lrelu_reg_slice.sv
source/lrelu_top.sv
testbench/lrelu_tb.sv

// ==== lrelu_engine/lrelu_config_fsm.sv ====
`timescale 1ns/1ps

module lrelu_config_fsm import lrelu_pkg::*; (
    input  logic       aclk,
    input  logic       arst_n,
    input  logic       s_tvalid,
    input  logic       s_tlast,
    input  logic       dw_ready,   // converter can take a wide beat
    input  logic       engine_en,  // slice can accept, pipeline advances
    input  logic       p_valid,    // datapath output side
    input  logic       p_last,
    output logic       s_tready,
    output logic       dw_valid,
    output logic       cfg_valid,
    output logic       cfg_clear,
    output logic       cfg_beat,
    output cfg_state_e state
);

    localparam int CNT_W = (CONFIG_BEATS > 1) ? $clog2(CONFIG_BEATS) : 1;

    cfg_state_e       state_next;
    logic [CNT_W-1:0] cfg_cnt;     // config beats taken so far in this iteration
    logic             handshake;
    logic             last_in;     // tlast accepted from the slave
    logic             last_out;    // final word of the iteration leaves the datapath
    logic             cfg_done;

    assign handshake = s_tvalid && s_tready;
    assign last_in   = handshake && s_tlast && (state == ST_PASS);
    assign last_out  = p_valid && p_last && engine_en;
    assign cfg_done  = handshake && (cfg_cnt == CNT_W'(CONFIG_BEATS - 1));

    always_comb begin
        state_next = state;
        case (state)
            ST_PASS:    if (last_in)   state_next = ST_BLOCK;
            ST_BLOCK:   if (last_out)  state_next = ST_RESET;
            ST_RESET:   if (engine_en) state_next = ST_WRITE_1;  // held until slice frees up
            ST_WRITE_1: if (handshake) state_next = (CONFIG_BEATS > 1) ? ST_WRITE_2 : ST_PASS;
            ST_WRITE_2: if (cfg_done)  state_next = ST_PASS;
            default:                   state_next = ST_PASS;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_WRITE_1;  // first beats after reset are config
            cfg_cnt <= '0;
        end else begin
            state <= state_next;
            if (cfg_valid) begin
                cfg_cnt <= cfg_done ? '0 : cfg_cnt + CNT_W'(1);
            end
        end
    end

    // route the slave stream by state
    always_comb begin
        case (state)
            ST_PASS:                s_tready = dw_ready;
            ST_WRITE_1, ST_WRITE_2: s_tready = engine_en;
            default:                s_tready = 1'b0;  // block and reset hold the input off
        endcase
    end

    assign dw_valid  = (state == ST_PASS) && s_tvalid;
    assign cfg_valid = (state == ST_WRITE_1 || state == ST_WRITE_2) && handshake;
    assign cfg_clear = (state == ST_RESET) && engine_en;  // single enabled cycle
    assign cfg_beat  = (state == ST_WRITE_2);

    // nothing may enter while the previous iteration drains or config is cleared
    a_no_ready_while_blocked: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (state == ST_BLOCK || state == ST_RESET) |-> !s_tready
    );

    a_state_legal: assert property (
        @(posedge aclk) disable iff (!arst_n)
        state inside {ST_PASS, ST_BLOCK, ST_RESET, ST_WRITE_1, ST_WRITE_2}
    );

endmodule

// ==== lrelu_engine/lrelu_datapath.sv ====
`timescale 1ns/1ps

module lrelu_datapath import lrelu_pkg::*; #(
    parameter int MEMBERS = 4,
    parameter int LANES   = 2
) (
    input  logic                                       aclk,
    input  logic                                       arst_n,
    input  logic                                       en,         // pipeline clock enable
    input  logic                                       cfg_valid,
    input  logic                                       cfg_clear,
    input  logic                                       cfg_beat,   // 0 first beat, 1 second
    input  logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] cfg_data,
    input  logic                                       s_valid,
    input  logic [LANES-1:0][ACC_WIDTH-1:0]            s_data,
    input  logic                                       s_last,
    output logic                                       m_valid,
    output logic [LANES-1:0][WORD_WIDTH-1:0]           m_data,
    output logic                                       m_last
);

    localparam int PROD_WIDTH = ACC_WIDTH + MULT_WIDTH;
    localparam int SAT_MAX    = (1 << (WORD_WIDTH - 1)) - 1;  // 127 for 8 bits
    localparam int SAT_MIN    = -(1 << (WORD_WIDTH - 1));     // -128

    // per-lane config
    logic signed [MULT_WIDTH-1:0]  mult_pos [LANES];
    logic signed [MULT_WIDTH-1:0]  mult_neg [LANES];
    logic        [SHIFT_WIDTH-1:0] shift    [LANES];

    // stage 1 products
    logic signed [PROD_WIDTH-1:0] s1_prod [LANES];
    logic                         s1_valid;
    logic                         s1_last;

    // stage 2 combinational terms
    logic signed [PROD_WIDTH:0]   half    [LANES];  // one extra bit for the round add
    logic signed [PROD_WIDTH:0]   rnd     [LANES];
    logic signed [PROD_WIDTH:0]   shifted [LANES];
    logic        [WORD_WIDTH-1:0] sat     [LANES];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < LANES; i++) begin
                mult_pos[i] <= '0;
                mult_neg[i] <= '0;
                shift[i]    <= '0;
            end
        end else if (cfg_clear) begin
            for (int i = 0; i < LANES; i++) begin
                mult_pos[i] <= '0;
                mult_neg[i] <= '0;
                shift[i]    <= '0;
            end
        end else if (cfg_valid) begin
            // lane i is configured by the member 0 word of lane i
            for (int i = 0; i < LANES; i++) begin
                if (!cfg_beat) begin
                    mult_pos[i] <= cfg_data[0][i][CFG_MULT_LSB +: MULT_WIDTH];
                    shift[i]    <= cfg_data[0][i][CFG_SHIFT_LSB +: SHIFT_WIDTH];
                end else begin
                    mult_neg[i] <= cfg_data[0][i][CFG_MULT_LSB +: MULT_WIDTH];
                end
            end
        end
    end

    // valid and last ride with the data
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            m_valid  <= 1'b0;
            m_last   <= 1'b0;
        end else if (en) begin
            s1_valid <= s_valid;
            s1_last  <= s_last && s_valid;
            m_valid  <= s1_valid;
            m_last   <= s1_last;
        end
    end

    // stage 1 sign picks the multiplier
    always_ff @(posedge aclk) begin
        if (en) begin
            for (int i = 0; i < LANES; i++) begin
                s1_prod[i] <= $signed(s_data[i]) *
                              (s_data[i][ACC_WIDTH-1] ? mult_neg[i] : mult_pos[i]);
            end
        end
    end

    // stage 2 round half up, arithmetic shift, clamp
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            half[i] = '0;
            if (shift[i] != '0) begin
                half[i][shift[i] - SHIFT_WIDTH'(1)] = 1'b1;
            end
            rnd[i]     = s1_prod[i] + half[i];
            shifted[i] = rnd[i] >>> shift[i];
            if (shifted[i] > SAT_MAX) begin
                sat[i] = WORD_WIDTH'(SAT_MAX);
            end else if (shifted[i] < SAT_MIN) begin
                sat[i] = WORD_WIDTH'(SAT_MIN);
            end else begin
                sat[i] = shifted[i][WORD_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (en) begin
            for (int i = 0; i < LANES; i++) begin
                m_data[i] <= sat[i];
            end
        end
    end

endmodule

// ==== lrelu_engine/lrelu_dw_converter.sv ====
`timescale 1ns/1ps

module lrelu_dw_converter import lrelu_pkg::*; #(
    parameter int MEMBERS = 4,
    parameter int LANES   = 2
) (
    input  logic                                       aclk,
    input  logic                                       arst_n,
    input  logic                                       s_valid,
    input  logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] s_data,
    input  logic                                       s_last,
    input  logic                                       m_ready,
    output logic                                       s_ready,
    output logic                                       m_valid,
    output logic [LANES-1:0][ACC_WIDTH-1:0]            m_data,
    output logic                                       m_last
);

    localparam int CNT_W = (MEMBERS > 1) ? $clog2(MEMBERS) : 1;

    logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] buf_data;  // held wide beat
    logic                                         buf_last;  // beat carried tlast
    logic [CNT_W-1:0]                             cnt;       // member now on the output
    logic                                         at_last;
    logic                                         load;
    logic                                         shift_out;

    assign at_last   = (cnt == CNT_W'(MEMBERS - 1));
    assign shift_out = m_valid && m_ready;
    // take a new beat when empty or when the final member goes out this cycle
    assign s_ready   = !m_valid || (shift_out && at_last);
    assign load      = s_valid && s_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid  <= 1'b0;
            cnt      <= '0;
            buf_last <= 1'b0;
        end else if (load) begin
            m_valid  <= 1'b1;
            cnt      <= '0;  // member 0 goes first
            buf_last <= s_last;
        end else if (shift_out) begin
            if (at_last) begin
                m_valid <= 1'b0;
            end else begin
                cnt <= cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            buf_data <= s_data;
        end
    end

    assign m_data = buf_data[cnt];
    assign m_last = buf_last && at_last;  // tlast only on the closing member

endmodule

// ==== source/lrelu_reg_slice.sv ====
`timescale 1ns/1ps

module lrelu_reg_slice import lrelu_pkg::*; #(
    parameter int LANES = 2
) (
    input  logic                             aclk,
    input  logic                             arst_n,
    input  logic                             s_valid,
    input  logic [LANES-1:0][WORD_WIDTH-1:0] s_data,
    input  logic                             s_last,
    input  logic                             m_ready,
    output logic                             s_ready,  // doubles as the engine enable
    output logic                             m_valid,
    output logic [LANES-1:0][WORD_WIDTH-1:0] m_data,
    output logic                             m_last
);

    // free when empty or when the held word leaves this cycle
    assign s_ready = !m_valid || m_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_ready && s_valid) begin
            m_data <= s_data;
            m_last <= s_last;
        end
    end

    // a stalled word stays put on the master side
    a_hold_on_stall: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last))
    );

endmodule

// ==== source/lrelu_top.sv ====
`timescale 1ns/1ps

module lrelu_top import lrelu_pkg::*; #(
    parameter int MEMBERS = 4,
    parameter int LANES   = 2
) (
    input  logic                                       aclk,
    input  logic                                       arst_n,
    input  logic                                       s_tvalid,
    input  logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] s_tdata,
    input  logic                                       s_tlast,
    input  logic                                       m_tready,
    output logic                                       s_tready,
    output logic                                       m_tvalid,
    output logic [LANES-1:0][WORD_WIDTH-1:0]           m_tdata,
    output logic                                       m_tlast,
    output cfg_state_e                                 debug_state
);

    logic                            dw_valid, dw_ready;
    logic                            cfg_valid, cfg_clear, cfg_beat;
    logic                            e_valid, e_last;   // converter to datapath
    logic [LANES-1:0][ACC_WIDTH-1:0] e_data;
    logic                            p_valid, p_last;   // datapath to slice
    logic [LANES-1:0][WORD_WIDTH-1:0] p_data;
    logic                            engine_en;

    lrelu_config_fsm u_fsm (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .s_tvalid  (s_tvalid),
        .s_tlast   (s_tlast),
        .dw_ready  (dw_ready),
        .engine_en (engine_en),
        .p_valid   (p_valid),
        .p_last    (p_last),
        .s_tready  (s_tready),
        .dw_valid  (dw_valid),
        .cfg_valid (cfg_valid),
        .cfg_clear (cfg_clear),
        .cfg_beat  (cfg_beat),
        .state     (debug_state)
    );

    lrelu_dw_converter #(.MEMBERS(MEMBERS), .LANES(LANES)) u_dw (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .s_valid (dw_valid),
        .s_data  (s_tdata),
        .s_last  (s_tlast),
        .m_ready (engine_en),
        .s_ready (dw_ready),
        .m_valid (e_valid),
        .m_data  (e_data),
        .m_last  (e_last)
    );

    // config beats come straight off the slave bus at full width
    lrelu_datapath #(.MEMBERS(MEMBERS), .LANES(LANES)) u_datapath (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .en        (engine_en),
        .cfg_valid (cfg_valid),
        .cfg_clear (cfg_clear),
        .cfg_beat  (cfg_beat),
        .cfg_data  (s_tdata),
        .s_valid   (e_valid),
        .s_data    (e_data),
        .s_last    (e_last),
        .m_valid   (p_valid),
        .m_data    (p_data),
        .m_last    (p_last)
    );

    lrelu_reg_slice #(.LANES(LANES)) u_slice (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .s_valid (p_valid),
        .s_data  (p_data),
        .s_last  (p_last),
        .m_ready (m_tready),
        .s_ready (engine_en),
        .m_valid (m_tvalid),
        .m_data  (m_tdata),
        .m_last  (m_tlast)
    );

endmodule

// ==== testbench/lrelu_tb.sv ====
`timescale 1ns/1ps

module lrelu_tb import lrelu_pkg::*; ();

    localparam int MEMBERS   = 4;
    localparam int LANES     = 2;
    localparam int NUM_TESTS = 6;

    localparam int MODE_RAND  = 0;  // mixed sign words
    localparam int MODE_NEG   = 1;  // only negative words
    localparam int MODE_EXT   = 2;  // full scale accumulators
    localparam int RDY_ALWAYS = 0;
    localparam int RDY_RANDOM = 1;
    localparam int RDY_TOGGLE = 2;

    typedef struct {
        int pos;    // lane 0 values that later lanes step up from
        int neg;
        int shift;
        int beats;  // wide data beats in the iteration
        int mode;
        int ready;  // m_tready pattern
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{40,   5,    9, 3, MODE_RAND, RDY_ALWAYS},
        '{100,  30,   11, 4, MODE_NEG,  RDY_RANDOM},
        '{1,    1,    0, 2, MODE_RAND, RDY_TOGGLE},  // lane 0 runs with no shift
        '{1000, 1000, 4, 5, MODE_EXT,  RDY_RANDOM},
        '{64,   12,   7, 3, MODE_RAND, RDY_RANDOM},
        '{20,   7,    6, 2, MODE_NEG,  RDY_ALWAYS}
    };

    logic                                         aclk;
    logic                                         arst_n;
    logic                                         s_tvalid;
    logic                                         s_tready;
    logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] s_tdata;
    logic                                         s_tlast;
    logic                                         m_tvalid;
    logic                                         m_tready;
    logic [LANES-1:0][WORD_WIDTH-1:0]             m_tdata;
    logic                                         m_tlast;
    cfg_state_e                                   debug_state;

    integer seed = 32'h8a58db05;

    // lane config of the iteration being sent
    logic signed [MULT_WIDTH-1:0]  lane_pos   [LANES];
    logic signed [MULT_WIDTH-1:0]  lane_neg   [LANES];
    logic        [SHIFT_WIDTH-1:0] lane_shift [LANES];

    logic signed [WORD_WIDTH-1:0] exp_words [$];  // member-major, lane inner
    logic                         exp_last  [$];  // one per output beat
    logic ready_draw = 1'b0;  // random ready bit drawn on the falling edge
    int ready_mode  = RDY_ALWAYS;
    int err_count   = 0;
    int check_count = 0;
    int test_errs   = 0;
    int test_beats  = 0;
    int tests_done  = 0;
    int out_beats   = 0;

    lrelu_top #(.MEMBERS(MEMBERS), .LANES(LANES)) uut (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .s_tvalid    (s_tvalid),
        .s_tdata     (s_tdata),
        .s_tlast     (s_tlast),
        .m_tready    (m_tready),
        .s_tready    (s_tready),
        .m_tvalid    (m_tvalid),
        .m_tdata     (m_tdata),
        .m_tlast     (m_tlast),
        .debug_state (debug_state)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // leaky relu requant picks the multiplier by sign, rounds half up, shifts and clamps
    function automatic logic signed [WORD_WIDTH-1:0] requant_word(
        input logic signed [ACC_WIDTH-1:0]   x,
        input logic signed [MULT_WIDTH-1:0]  mp,
        input logic signed [MULT_WIDTH-1:0]  mn,
        input logic        [SHIFT_WIDTH-1:0] sh
    );
        longint acc;
        longint hi;
        longint lo;
        hi  = (longint'(1) << (WORD_WIDTH - 1)) - 1;
        lo  = -(longint'(1) << (WORD_WIDTH - 1));
        acc = longint'(x) * ((x < 0) ? longint'(mn) : longint'(mp));
        if (sh != 0) begin
            acc = acc + (longint'(1) << (sh - 1));
        end
        acc = acc >>> sh;
        if (acc > hi) begin
            acc = hi;
        end else if (acc < lo) begin
            acc = lo;
        end
        return acc[WORD_WIDTH-1:0];
    endfunction

    function automatic logic [ACC_WIDTH-1:0] make_word(input int mode, input int idx);
        int r;
        logic [ACC_WIDTH-1:0] word;
        r = $random(seed);
        case (mode)
            MODE_NEG: word = -((r & 32'h7ff) + 1);  // -1 down to -2048
            MODE_EXT: begin
                case (idx % 4)
                    0:       word = 32'h7fffffff;
                    1:       word = 32'h80000000;
                    2:       word = 32'h40000000 + (r & 32'hffff);
                    default: word = 32'hc0000000 - (r & 32'hffff);
                endcase
            end
            default:  word = r % 2048;  // both signs, mostly in range after scaling
        endcase
        return word;
    endfunction

    // member 0 word of lane i carries the fields and the rest is junk
    function automatic logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] config_beat(
        input logic second
    );
        logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] beat;
        for (int m = 0; m < MEMBERS; m++) begin
            for (int l = 0; l < LANES; l++) begin
                beat[m][l] = $random(seed);
            end
        end
        for (int l = 0; l < LANES; l++) begin
            beat[0][l][15:0] = second ? lane_neg[l] : lane_pos[l];
            if (!second) begin
                beat[0][l][20:16] = lane_shift[l];
            end
        end
        return beat;
    endfunction

    function automatic int total_member_beats();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            sum += tests[t].beats * MEMBERS;
        end
        return sum;
    endfunction

    task automatic check_word(input logic signed [WORD_WIDTH-1:0] act,
                              input logic signed [WORD_WIDTH-1:0] exp, input string name);
        check_count++;
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        check_count++;
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_state(input cfg_state_e act, input cfg_state_e exp, input string name);
        check_count++;
        if (act !== exp) begin
            $display("FAIL %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
            err_count++;
            test_errs++;
        end
    endtask

    // present one wide beat and return on the edge that takes it
    task automatic send_beat(input logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] data,
                             input logic last);
        s_tvalid <= 1'b1;
        s_tdata  <= data;
        s_tlast  <= last;
        @(posedge aclk);
        while (!s_tready) begin
            @(posedge aclk);
        end
    endtask

    always @(negedge aclk) begin
        ready_draw = (($random(seed) & 1) == 1);
    end

    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_tready <= 1'b0;
        end else begin
            case (ready_mode)
                RDY_RANDOM: m_tready <= ready_draw;
                RDY_TOGGLE: m_tready <= !m_tready;
                default:    m_tready <= 1'b1;
            endcase
        end
    end

    // output monitor prints one line per finished iteration
    always @(posedge aclk) begin
        logic last_exp;
        if (arst_n && m_tvalid && m_tready) begin
            if (exp_last.size() == 0) begin
                $display("output beat at %0t arrived with nothing expected", $time);
                err_count++;
            end else begin
                for (int l = 0; l < LANES; l++) begin
                    check_word(m_tdata[l], exp_words.pop_front(), $sformatf("m_tdata[%0d]", l));
                end
                last_exp = exp_last.pop_front();
                check_bit(m_tlast, last_exp, "m_tlast");
                out_beats++;
                test_beats++;
                if (last_exp) begin
                    $display("test %0d done: %0d output beats, %0d errors",
                             tests_done, test_beats, test_errs);
                    tests_done++;
                    test_beats = 0;
                    test_errs  = 0;
                end
            end
        end
    end

    initial begin
        logic [MEMBERS-1:0][LANES-1:0][ACC_WIDTH-1:0] beat;
        int word_idx;
        arst_n   = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tlast  = 1'b0;
        m_tready = 1'b0;
        word_idx = 0;
        repeat (16) @(posedge aclk);
        arst_n <= 1'b1;
        @(posedge aclk);
        check_state(debug_state, ST_WRITE_1, "debug_state");  // config expected first
        check_bit(m_tvalid, 1'b0, "m_tvalid");
        for (int t = 0; t < NUM_TESTS; t++) begin
            ready_mode = tests[t].ready;
            for (int l = 0; l < LANES; l++) begin
                lane_pos[l]   = tests[t].pos + 7 * l;
                lane_neg[l]   = tests[t].neg + 3 * l;
                lane_shift[l] = tests[t].shift + l;
            end
            send_beat(config_beat(1'b0), 1'b0);
            send_beat(config_beat(1'b1), 1'b0);
            for (int b = 0; b < tests[t].beats; b++) begin
                for (int m = 0; m < MEMBERS; m++) begin
                    for (int l = 0; l < LANES; l++) begin
                        beat[m][l] = make_word(tests[t].mode, word_idx);
                        word_idx++;
                        exp_words.push_back(requant_word(beat[m][l], lane_pos[l],
                                                         lane_neg[l], lane_shift[l]));
                    end
                    exp_last.push_back(b == tests[t].beats - 1 && m == MEMBERS - 1);
                end
                send_beat(beat, b == tests[t].beats - 1);  // next config follows at once
            end
        end
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        wait (tests_done == NUM_TESTS);
        repeat (8) @(posedge aclk);  // room for stray extra beats
        if (out_beats != total_member_beats() || exp_words.size() != 0) begin
            $display("output beat count is %0d but %0d were sent", out_beats,
                     total_member_beats());
            err_count++;
        end
        $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // cycle budget scales with the member beats in the table
    initial begin
        int limit;
        int cycles;
        limit  = 8 * total_member_beats() + 200;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule
